//--- testbench/game_vectors.txt
// Columns in hex: key, steps, probe x, probe y, red, green, blue, led, number
// Each row waits its steps of 4 clocks, then checks colours, led and display
00 1   005 064 00 00 1f 90 01900180
00 1   19a 186 1f 00 00 90 01900180
00 1   0c8 0c8 00 00 00 90 01900180
80 2   022 07d 00 00 1f 90 00050060
00 a   00f 060 00 00 1f 90 01900180
80 4   030 07d 00 00 1f 90 00130060
00 5c  06f 060 00 00 1f 90 01900180
08 1   19a 186 1f 00 00 90 01900180
00 a   190 176 1f 00 00 90 01900176
01 5   1b2 171 1f 00 00 95 01950171
08 5   18f 16c 00 00 00 90 0190016c
00 ef  2bc 00a 1f 00 00 90 0190007d
00 64  003 1d6 1f 00 00 90 0190007d
00 2   000 060 00 00 1f 90 01900180
00 c8  0e5 07d 00 00 1f 90 01900180
80 1   19a 186 1f 00 00 90 00c90060
00 1   190 17f 1f 00 00 90 0190017f
00 17e 19a 005 1f 00 00 90 01900001
00 1   31f 1df 1f 3f 00 90 01900000
00 64  000 000 1f 3f 00 90 01900000
80 2   000 060 00 00 1f 90 00000060

//--- tb.f
design/game_pkg.sv
design/game_input.sv
design/game_fsm.sv
design/object_motion.sv
design/pixel_painter.sv
design/seven_segment_display.sv
design/shooting_game_top.sv
testbench/tb_shooting_game.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the shooting game testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_shooting_game -f tb.f -o sim_game \
    && ./obj_dir/sim_game 2>&1 | tee sim.log

grep -q "All checks passed" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- testbench/tb_shooting_game.sv
// Vector-driven testbench for shooting_game_top with clocks_per_tick set to 4
// Run from the project root so that the vector file path resolves

`timescale 1ns/100ps

module tb_shooting_game;

    localparam int tick_clocks = 4;
    localparam int fields      = 9;
    localparam int max_vectors = 32;
    localparam int align_limit = 64;

    // Shot start x of 400, low byte as seen on led
    localparam logic [7:0] shot_start_led = 8'h90;

    logic               clock;
    logic               reset;
    game_pkg::key_t     key;
    game_pkg::coord_t   x;
    game_pkg::coord_t   y;
    logic [7:0]         led;
    logic [7:0]         abcdefgh;
    logic [7:0]         digit;
    game_pkg::red_t     red;
    game_pkg::green_t   green;
    game_pkg::blue_t    blue;

    // Nine words per vector, filled with ones past the last vector
    logic [31:0]        vector_mem [0:fields * max_vectors - 1];
    int                 check_count;
    int                 current_vector;

    shooting_game_top #(.clocks_per_tick(tick_clocks)) uut
    (
        .clock    (clock),
        .reset    (reset),
        .key      (key),
        .x        (x),
        .y        (y),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    // 4 ns clock
    always #2 clock = ~clock;

    //------------------------------------------------------------------------
    // Checks

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("Error at %0.1f ns: vector %0d %s is %h, expected %h",
                     $realtime, current_vector, name, actual, expected);
            $display("Checks failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Standard hex font, a in bit 7, dot in bit 0 and dark
    function automatic logic [7:0] segments_for(input logic [3:0] value);
        logic [7:0] seg;
        case (value)
            4'h0:    seg = 8'hfc;
            4'h1:    seg = 8'h60;
            4'h2:    seg = 8'hda;
            4'h3:    seg = 8'hf2;
            4'h4:    seg = 8'h66;
            4'h5:    seg = 8'hb6;
            4'h6:    seg = 8'hbe;
            4'h7:    seg = 8'he0;
            4'h8:    seg = 8'hfe;
            4'h9:    seg = 8'hf6;
            4'ha:    seg = 8'hee;
            4'hb:    seg = 8'h3e;
            4'hc:    seg = 8'h9c;
            4'hd:    seg = 8'h7a;
            4'he:    seg = 8'h9e;
            default: seg = 8'h8e;
        endcase
        return seg;
    endfunction

    // Whichever digit is lit must show its nibble of the number
    task automatic check_display(input logic [31:0] number);
        int active;
        active = 0;
        for (int i = 0; i < 8; i++)
        begin
            if (digit[i])
                active = i;
        end
        check_value("digit one-hot count", 32'($countones(digit)), 32'd1);
        check_value("abcdefgh", 32'(abcdefgh), 32'(segments_for(number[active * 4 +: 4])));
    endtask

    //------------------------------------------------------------------------
    // Waits

    // Each clock ends at the drive point, 0.5 ns after the edge
    task automatic wait_clocks(input int count);
        for (int i = 0; i < count; i++)
        begin
            @(posedge clock);
            #0.5;
        end
    endtask

    // First game step puts the shot at its start x
    task automatic wait_first_step();
        int waited;
        waited = 0;
        while (led !== shot_start_led && waited < align_limit)
        begin
            @(posedge clock);
            #0.5;
            waited++;
        end
        if (led !== shot_start_led)
        begin
            $display("Timeout: the first game step did not happen after reset");
            $display("Checks failed");
            $fatal(1, "No first game step");
        end
    endtask

    //------------------------------------------------------------------------
    // Stimulus

    initial
    begin
        int base;

        clock          = 1'b0;
        reset          = 1'b1;
        key            = '0;
        x              = '0;
        y              = '0;
        check_count    = 0;
        current_vector = 0;
        base           = 0;

        for (int i = 0; i < fields * max_vectors; i++)
            vector_mem[i] = '1;
        $readmemh("testbench/game_vectors.txt", vector_mem);

        // Reset for 5 clocks
        repeat (5) @(posedge clock);
        #0.5;
        reset = 1'b0;

        // Now at the drive point just after step 1
        wait_first_step();

        while (current_vector < max_vectors && vector_mem[base] !== 32'hffff_ffff)
        begin
            key = vector_mem[base][7:0];
            x   = vector_mem[base + 2][9:0];
            y   = vector_mem[base + 3][9:0];

            // Steps counted in clocks
            wait_clocks(int'(vector_mem[base + 1]) * tick_clocks);

            // Sampled before the next vector drives anything
            check_value("red", 32'(red), vector_mem[base + 4]);
            check_value("green", 32'(green), vector_mem[base + 5]);
            check_value("blue", 32'(blue), vector_mem[base + 6]);
            check_value("led", 32'(led), vector_mem[base + 7]);
            check_display(vector_mem[base + 8]);

            current_vector++;
            base = base + fields;
        end

        if (check_count > 0)
        begin
            $display("All checks passed");
            $finish;
        end
        else
        begin
            $display("No vectors were read from the vector file");
            $display("Checks failed");
            $fatal(1, "Empty vector file");
        end
    end

endmodule

//--- design/shooting_game_top.sv
// Top level of the shooting game. LCD x and y come from an outside timing generator
// clocks_per_tick sets the game speed, 270000 on the board

`timescale 1ns/100ps

module shooting_game_top
#(
    parameter int clocks_per_tick = 270000,
    parameter int screen_width    = 800,
    parameter int screen_height   = 480,
    parameter int object_size     = 30,
    parameter int result_ticks    = 200,
    parameter int aim_ticks       = 100
)
(
    input  logic                clock,
    input  logic                reset,
    input  game_pkg::key_t      key,
    input  game_pkg::coord_t    x,
    input  game_pkg::coord_t    y,
    output logic [7:0]          led,
    output logic [7:0]          abcdefgh,
    output logic [7:0]          digit,
    output game_pkg::red_t      red,
    output game_pkg::green_t    green,
    output game_pkg::blue_t     blue
);

    logic                   tick;
    logic                   launch;
    logic                   steer_right;
    logic                   steer_left;
    logic                   show_target;
    logic                   out_of_screen;
    logic                   hit;
    game_pkg::game_state_t  state;
    game_pkg::coord_t       target_x;
    game_pkg::coord_t       target_y;
    game_pkg::coord_t       shot_x;
    game_pkg::coord_t       shot_y;
    logic [31:0]            number;

    //------------------------------------------------------------------------
    // Input side

    game_input #(.clocks_per_tick(clocks_per_tick)) i_input
    (
        .clock       (clock),
        .reset       (reset),
        .key         (key),
        .tick        (tick),
        .launch      (launch),
        .steer_right (steer_right),
        .steer_left  (steer_left),
        .show_target (show_target)
    );

    //------------------------------------------------------------------------
    // Processing part

    game_fsm #(.result_ticks(result_ticks), .aim_ticks(aim_ticks)) i_fsm
    (
        .clock         (clock),
        .reset         (reset),
        .tick          (tick),
        .launch        (launch),
        .out_of_screen (out_of_screen),
        .hit           (hit),
        .state         (state)
    );

    object_motion
    #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .object_size   (object_size)
    )
    i_motion
    (
        .clock         (clock),
        .reset         (reset),
        .tick          (tick),
        .steer_right   (steer_right),
        .steer_left    (steer_left),
        .state         (state),
        .target_x      (target_x),
        .target_y      (target_y),
        .shot_x        (shot_x),
        .shot_y        (shot_y),
        .out_of_screen (out_of_screen),
        .hit           (hit)
    );

    //------------------------------------------------------------------------
    // Output side

    pixel_painter
    #(
        .screen_width  (screen_width),
        .screen_height (screen_height),
        .object_size   (object_size)
    )
    i_painter
    (
        .state    (state),
        .x        (x),
        .target_x (target_x),
        .target_y (target_y),
        .shot_x   (shot_x),
        .shot_y   (shot_y),
        .y        (y),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

    // Upper half x, lower half y, of the target with key 7 or else the shot
    assign number = show_target ? {6'b0, target_x, 6'b0, target_y}
                                : {6'b0, shot_x,   6'b0, shot_y};

    seven_segment_display i_display
    (
        .clock    (clock),
        .reset    (reset),
        .number   (number),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    // Low byte of the shot x position
    assign led = shot_x[7:0];

endmodule

//--- design/seven_segment_display.sv
// Eight-digit hex scanner, one digit per clock
// Segments and digit selects are active high. The dot stays off

`timescale 1ns/100ps

module seven_segment_display
(
    input  logic         clock,
    input  logic         reset,
    input  logic [31:0]  number,
    output logic [7:0]   abcdefgh,
    output logic [7:0]   digit
);

    logic [2:0] index;
    logic [3:0] nibble;

    //------------------------------------------------------------------------
    // Hex to segments, a in the top bit, dot in the bottom bit

    function automatic logic [7:0] hex_segments(input logic [3:0] value);
        logic [7:0] seg;
        case (value)
            4'h0:    seg = 8'b1111_1100;
            4'h1:    seg = 8'b0110_0000;
            4'h2:    seg = 8'b1101_1010;
            4'h3:    seg = 8'b1111_0010;
            4'h4:    seg = 8'b0110_0110;
            4'h5:    seg = 8'b1011_0110;
            4'h6:    seg = 8'b1011_1110;
            4'h7:    seg = 8'b1110_0000;
            4'h8:    seg = 8'b1111_1110;
            4'h9:    seg = 8'b1111_0110;
            4'ha:    seg = 8'b1110_1110;
            4'hb:    seg = 8'b0011_1110;
            4'hc:    seg = 8'b1001_1100;
            4'hd:    seg = 8'b0111_1010;
            4'he:    seg = 8'b1001_1110;
            default: seg = 8'b1000_1110;
        endcase
        return seg;
    endfunction

    //------------------------------------------------------------------------
    // Scan position
    // Index and one-hot select step together and wrap after digit 7

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            index <= '0;
            digit <= 8'b0000_0001;
        end
        else
        begin
            index <= index + 1'b1;
            digit <= {digit[6:0], digit[7]};
        end
    end

    // Digit i shows bits 4i+3 down to 4i
    assign nibble   = number[{index, 2'b00} +: 4];
    assign abcdefgh = hex_segments(nibble);

    // Select stays one-hot and in step with the nibble index
    digit_one_hot: assert property (@(posedge clock) disable iff (reset)
        $onehot(digit) && digit[index]);

endmodule

//--- design/pixel_painter.sv
// Colour of one LCD pixel, purely combinational
// Pixels outside the visible area stay black

`timescale 1ns/100ps

module pixel_painter
#(
    parameter int screen_width  = 800,
    parameter int screen_height = 480,
    parameter int object_size   = 30
)
(
    input  game_pkg::game_state_t   state,
    input  game_pkg::coord_t        x,
    input  game_pkg::coord_t        target_x,
    input  game_pkg::coord_t        target_y,
    input  game_pkg::coord_t        shot_x,
    input  game_pkg::coord_t        shot_y,
    input  game_pkg::coord_t        y,
    output game_pkg::red_t          red,
    output game_pkg::green_t        green,
    output game_pkg::blue_t         blue
);

    localparam logic [10:0] size_w   = 11'(object_size);
    localparam logic [10:0] width_w  = 11'(screen_width);
    localparam logic [10:0] height_w = 11'(screen_height);

    logic visible;
    logic in_target;
    logic in_shot;

    assign visible   = ({1'b0, x} < width_w) && ({1'b0, y} < height_w);

    // Inside test against each square, far sides exclusive
    assign in_target = (x >= target_x) && ({1'b0, x} < {1'b0, target_x} + size_w)
                    && (y >= target_y) && ({1'b0, y} < {1'b0, target_y} + size_w);
    assign in_shot   = (x >= shot_x) && ({1'b0, x} < {1'b0, shot_x} + size_w)
                    && (y >= shot_y) && ({1'b0, y} < {1'b0, shot_y} + size_w);

    always_comb
    begin
        red   = '0;
        green = '0;
        blue  = '0;

        if (visible)
        begin
            case (state)
                // Won screen is flat red
                game_pkg::st_won:
                    red = game_pkg::max_red;

                // Lost screen is flat yellow
                game_pkg::st_lost:
                begin
                    red   = game_pkg::max_red;
                    green = game_pkg::max_green;
                end

                default:
                begin
                    // Both squares may share a pixel
                    if (in_target)
                        blue = game_pkg::max_blue;
                    if (in_shot)
                        red = game_pkg::max_red;
                end
            endcase
        end
    end

endmodule

//--- design/object_motion.sv
// Positions move only on a tick. Flags look at the positions of that tick
// Objects freeze in the won and lost states

`timescale 1ns/100ps

module object_motion
#(
    parameter int screen_width  = 800,
    parameter int screen_height = 480,
    parameter int object_size   = 30
)
(
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    tick,
    input  logic                    steer_right,
    input  logic                    steer_left,
    input  game_pkg::game_state_t   state,
    output game_pkg::coord_t        target_x,
    output game_pkg::coord_t        target_y,
    output game_pkg::coord_t        shot_x,
    output game_pkg::coord_t        shot_y,
    output logic                    out_of_screen,
    output logic                    hit
);

    // Start positions
    localparam game_pkg::coord_t target_start_x = '0;
    localparam game_pkg::coord_t target_start_y = game_pkg::coord_t'(screen_height / 5);
    localparam game_pkg::coord_t shot_start_x   = game_pkg::coord_t'(screen_width / 2);
    localparam game_pkg::coord_t shot_start_y   = game_pkg::coord_t'(screen_height * 4 / 5);

    localparam game_pkg::coord_t width_edge = game_pkg::coord_t'(screen_width);

    // Square size in one bit more than a coordinate
    localparam logic [10:0] size_w = 11'(object_size);

    game_pkg::coord_t   target_x_next;
    game_pkg::coord_t   target_y_next;
    game_pkg::coord_t   shot_x_next;
    game_pkg::coord_t   shot_y_next;

    // Far sides of both squares
    logic [10:0]        target_right;
    logic [10:0]        target_bottom;
    logic [10:0]        shot_right;
    logic [10:0]        shot_bottom;

    //------------------------------------------------------------------------
    // Next positions

    always_comb
    begin
        target_x_next = target_x;
        target_y_next = target_y;
        shot_x_next   = shot_x;
        shot_y_next   = shot_y;

        case (state)
            game_pkg::st_start:
            begin
                target_x_next = target_start_x;
                target_y_next = target_start_y;
                shot_x_next   = shot_start_x;
                shot_y_next   = shot_start_y;
            end

            game_pkg::st_aim:
                target_x_next = target_x + 1'b1;

            game_pkg::st_shoot:
            begin
                target_x_next = target_x + 1'b1;
                // Holding both steer keys cancels out
                shot_x_next   = shot_x + game_pkg::coord_t'(steer_right)
                                       - game_pkg::coord_t'(steer_left);
                shot_y_next   = shot_y - 1'b1;
            end

            // Won and lost hold both squares in place
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            target_x <= '0;
            target_y <= '0;
            shot_x   <= '0;
            shot_y   <= '0;
        end
        else if (tick)
        begin
            target_x <= target_x_next;
            target_y <= target_y_next;
            shot_x   <= shot_x_next;
            shot_y   <= shot_y_next;
        end
    end

    //------------------------------------------------------------------------
    // Edge and overlap tests on the next positions

    assign out_of_screen = (target_x_next == width_edge)
                         | (shot_x_next   == '0)
                         | (shot_x_next   == width_edge)
                         | (shot_y_next   == '0);

    assign target_right  = {1'b0, target_x_next} + size_w;
    assign target_bottom = {1'b0, target_y_next} + size_w;
    assign shot_right    = {1'b0, shot_x_next}   + size_w;
    assign shot_bottom   = {1'b0, shot_y_next}   + size_w;

    // Overlap unless one square lies fully to one side of the other
    assign hit = !(  (target_right  <= {1'b0, shot_x_next})
                   | (shot_right    <= {1'b0, target_x_next})
                   | (target_bottom <= {1'b0, shot_y_next})
                   | (shot_bottom   <= {1'b0, target_y_next}));

endmodule

//--- design/game_fsm.sv
// One timer serves as aim timeout and as result delay
// State moves only on a tick. Timer reloads on every clock in start and shoot

`timescale 1ns/100ps

module game_fsm
#(
    parameter int result_ticks = 200,
    parameter int aim_ticks    = 100
)
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      tick,
    input  logic                      launch,
    input  logic                      out_of_screen,
    input  logic                      hit,
    output game_pkg::game_state_t     state
);

    localparam game_pkg::timer_t result_load = game_pkg::timer_t'(result_ticks);
    localparam game_pkg::timer_t aim_load    = game_pkg::timer_t'(aim_ticks);

    game_pkg::game_state_t  state_next;
    game_pkg::timer_t       timer;
    logic                   timeout;

    //------------------------------------------------------------------------
    // Next state
    // Edge beats overlap, overlap beats launch or timeout

    always_comb
    begin
        state_next = state;

        case (state)
            game_pkg::st_start:
                state_next = game_pkg::st_aim;

            game_pkg::st_aim:
                if (out_of_screen)
                    state_next = game_pkg::st_lost;
                else if (hit)
                    state_next = game_pkg::st_won;
                else if (launch || timeout)
                    state_next = game_pkg::st_shoot;

            game_pkg::st_shoot:
                if (out_of_screen)
                    state_next = game_pkg::st_lost;
                else if (hit)
                    state_next = game_pkg::st_won;

            game_pkg::st_won, game_pkg::st_lost:
                if (timeout)
                    state_next = game_pkg::st_start;

            default:
                state_next = game_pkg::st_start;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            state <= game_pkg::st_start;
        else if (tick)
            state <= state_next;
    end

    //------------------------------------------------------------------------
    // Shared timer

    always_ff @(posedge clock)
    begin
        if (reset)
            timer <= '0;
        else if (state == game_pkg::st_start)
            timer <= result_load;
        else if (state == game_pkg::st_shoot)
            timer <= aim_load;
        else if (tick)
            timer <= timer - 1'b1;
    end

    assign timeout = (timer == '0);

    //------------------------------------------------------------------------
    // Checks

    state_legal: assert property (@(posedge clock) disable iff (reset)
        state inside {game_pkg::st_start, game_pkg::st_aim, game_pkg::st_shoot,
                      game_pkg::st_won, game_pkg::st_lost});

    // Overlap flag from object_motion must have been high on the entering tick
    won_needs_hit: assert property (@(posedge clock) disable iff (reset)
        $rose(state == game_pkg::st_won) |-> $past(hit));

endmodule

//--- design/game_input.sv
// Keys go through two flops only, with no debounce
// The tick counter needs clocks_per_tick of 2 or more

`timescale 1ns/100ps

module game_input
#(
    parameter int clocks_per_tick = 270000
)
(
    input  logic            clock,
    input  logic            reset,
    input  game_pkg::key_t  key,
    output logic            tick,
    output logic            launch,
    output logic            steer_right,
    output logic            steer_left,
    output logic            show_target
);

    // Room for the last count value
    localparam int count_w = $clog2(clocks_per_tick + 1);
    localparam logic [count_w - 1:0] last_count = count_w'(clocks_per_tick - 1);

    game_pkg::key_t         key_meta;
    game_pkg::key_t         key_sync;
    logic [count_w - 1:0]   count;

    //------------------------------------------------------------------------
    // Two-flop key synchronizer

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            key_meta <= '0;
            key_sync <= '0;
        end
        else
        begin
            key_meta <= key;
            key_sync <= key_meta;
        end
    end

    // Key decode
    assign steer_right = key_sync[0];
    assign steer_left  = |key_sync[6:1];
    assign launch      = |key_sync[6:0];
    assign show_target = key_sync[7];

    //------------------------------------------------------------------------
    // Tick strobe divider
    // First strobe follows clocks_per_tick edges after reset release

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            count <= '0;
            tick  <= 1'b0;
        end
        else if (count == last_count)
        begin
            count <= '0;
            tick  <= 1'b1;
        end
        else
        begin
            count <= count + 1'b1;
            tick  <= 1'b0;
        end
    end

    // Strobe is one clock wide
    tick_single_clock: assert property (@(posedge clock) disable iff (reset)
        tick |=> !tick);

endmodule

//--- design/game_pkg.sv
// Shared types for the shooting game on an 800 by 480 LCD
// Coordinates are 10 bits wide so that 800 fits. Colours follow 5-6-5 RGB

package game_pkg;

    //------------------------------------------------------------------------
    // Vector types

    // Screen coordinate, pixels
    typedef logic [9:0] coord_t;

    // Raw key vector from the board
    typedef logic [7:0] key_t;

    // LCD colour channels
    typedef logic [4:0] red_t;
    typedef logic [5:0] green_t;
    typedef logic [4:0] blue_t;

    // Aim and result timer, counted in game ticks
    typedef logic [7:0] timer_t;

    //------------------------------------------------------------------------
    // Game states

    typedef enum logic [2:0]
    {
        st_start = 3'd0,
        st_aim   = 3'd1,
        st_shoot = 3'd2,
        st_won   = 3'd3,
        st_lost  = 3'd4
    } game_state_t;

    //------------------------------------------------------------------------
    // Full colour levels

    parameter red_t   max_red   = 5'd31;
    parameter green_t max_green = 6'd63;
    parameter blue_t  max_blue  = 5'd31;

endpackage
